/* hdl/raster_cfg_pkg.sv */
// ############################
// Framebuffer geometry, buffer map and width types
// shared by the rasterizer core and its testbench
// ############################

package raster_cfg_pkg;

    // screen size in pixels
    localparam int FB_WIDTH  = 32;
    localparam int FB_HEIGHT = 16;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;

    // front and back buffer word addresses after reset
    localparam int FRONT_INIT_BASE = 0;
    localparam int BACK_INIT_BASE  = FB_PIXELS;

    // fraction bits of a vertex coordinate
    localparam int SUBPIXEL_BITS = 4;

    typedef logic signed [15:0] coord_t;
    typedef logic signed [11:0] pix_coord_t;
    typedef logic        [31:0] vram_addr_t;
    typedef logic        [15:0] color_t;
    typedef logic signed [31:0] edge_t;

endpackage

/* hdl/raster_cmd_pkg.sv */
// ############################
// Command word encoding and the structs passed
// between decoder, engines and VRAM writer
// ############################

package raster_cmd_pkg;

    // opcode field of a command word, operand is always bits 15:0
    localparam int OP_POS  = 24;
    localparam int OP_SIZE = 8;

    typedef enum logic [7:0] {
        OP_SET_X0    = 8'h00,
        OP_SET_Y0    = 8'h01,
        OP_SET_X1    = 8'h02,
        OP_SET_Y1    = 8'h03,
        OP_SET_X2    = 8'h04,
        OP_SET_Y2    = 8'h05,
        OP_SET_COLOR = 8'h06,
        OP_CLEAR     = 8'h07,
        OP_DRAW      = 8'h08,
        // bit 0 of the operand selects a swap on vsync
        OP_SWAP      = 8'h09
    } opcode_e;

    // 12.4 fixed point screen position
    typedef struct packed {
        raster_cfg_pkg::coord_t x;
        raster_cfg_pkg::coord_t y;
    } vertex_t;

    typedef struct packed {
        vertex_t                v0;
        vertex_t                v1;
        vertex_t                v2;
        raster_cfg_pkg::color_t color;
    } triangle_t;

    // one pixel write toward VRAM
    typedef struct packed {
        raster_cfg_pkg::vram_addr_t addr;
        raster_cfg_pkg::color_t     data;
    } pix_write_t;

endpackage

/* hdl/cmd_decoder.sv */
// ############################
// Command stream front end: loads triangle registers,
// launches clear/draw engines and swaps buffers
// ############################

`timescale 1ns/10ps

module cmd_decoder (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       cmd_valid_i,
    input  logic [31:0]                cmd_data_i,
    output logic                       cmd_ready_o,
    input  logic                       vsync_i,
    input  logic                       raster_busy_i,
    input  logic                       clear_busy_i,
    output logic                       raster_start_o,
    output logic                       clear_start_o,
    output raster_cmd_pkg::triangle_t  tri_o,
    output raster_cfg_pkg::color_t     clear_color_o,
    output raster_cfg_pkg::vram_addr_t back_base_o,
    output raster_cfg_pkg::vram_addr_t front_addr_o,
    output logic                       swap_o
);
    import raster_cfg_pkg::*;
    import raster_cmd_pkg::*;

    typedef enum logic [1:0] {IDLE, WAIT_ENGINE, WAIT_VSYNC} state_e;

    state_e  state;
    opcode_e opcode;
    color_t  operand;
    logic    xfer;
    logic    do_swap;

    assign opcode  = opcode_e'(cmd_data_i[OP_POS +: OP_SIZE]);
    assign operand = cmd_data_i[15:0];
    // hold off one cycle after a swap so swap pulses never merge
    assign cmd_ready_o = (state == IDLE) && !swap_o;
    assign xfer        = cmd_valid_i && cmd_ready_o;
    assign do_swap = (xfer && opcode == OP_SWAP && !cmd_data_i[0]) ||
                     (state == WAIT_VSYNC && vsync_i);

    always_ff @(posedge clk) begin
        raster_start_o <= 1'b0;
        clear_start_o  <= 1'b0;
        swap_o         <= 1'b0;

        case (state)
            IDLE: begin
                if (xfer) begin
                    case (opcode)
                        OP_SET_X0:    tri_o.v0.x  <= operand;
                        OP_SET_Y0:    tri_o.v0.y  <= operand;
                        OP_SET_X1:    tri_o.v1.x  <= operand;
                        OP_SET_Y1:    tri_o.v1.y  <= operand;
                        OP_SET_X2:    tri_o.v2.x  <= operand;
                        OP_SET_Y2:    tri_o.v2.y  <= operand;
                        OP_SET_COLOR: tri_o.color <= operand;
                        OP_CLEAR: begin
                            clear_color_o <= operand;
                            clear_start_o <= 1'b1;
                            state         <= WAIT_ENGINE;
                        end
                        OP_DRAW: begin
                            raster_start_o <= 1'b1;
                            state          <= WAIT_ENGINE;
                        end
                        OP_SWAP: begin
                            if (cmd_data_i[0]) begin
                                state <= WAIT_VSYNC;
                            end
                        end
                        // unknown words are dropped
                        default: ;
                    endcase
                end
            end

            WAIT_ENGINE: begin
                // busy only rises on the edge after the start pulse
                if (!raster_start_o && !clear_start_o && !raster_busy_i && !clear_busy_i) begin
                    state <= IDLE;
                end
            end

            WAIT_VSYNC: begin
                if (vsync_i) begin
                    state <= IDLE;
                end
            end

            default: state <= IDLE;
        endcase

        if (do_swap) begin
            front_addr_o <= back_base_o;
            back_base_o  <= front_addr_o;
            swap_o       <= 1'b1;
        end

        if (reset_i) begin
            state          <= IDLE;
            raster_start_o <= 1'b0;
            clear_start_o  <= 1'b0;
            swap_o         <= 1'b0;
            front_addr_o   <= vram_addr_t'(FRONT_INIT_BASE);
            back_base_o    <= vram_addr_t'(BACK_INIT_BASE);
        end
    end

endmodule

/* hdl/edge_rasterizer.sv */
// ############################
// Flat triangle fill: clipped bounding box walk,
// one edge-function test per pixel per cycle
// ############################

`timescale 1ns/10ps

module edge_rasterizer (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       start_i,
    input  raster_cmd_pkg::triangle_t  tri_i,
    input  raster_cfg_pkg::vram_addr_t base_i,
    output logic                       wr_valid_o,
    output raster_cmd_pkg::pix_write_t wr_o,
    input  logic                       wr_ready_i,
    input  logic                       writer_idle_i,
    output logic                       busy_o
);
    import raster_cfg_pkg::*;
    import raster_cmd_pkg::*;

    typedef enum logic [1:0] {R_IDLE, R_SETUP, R_WALK, R_DRAIN} state_e;

    state_e     state;
    triangle_t  tri_q;
    vram_addr_t base_q;
    pix_coord_t min_x, min_y, max_x, max_y;
    pix_coord_t lo_x, lo_y, hi_x, hi_y;
    pix_coord_t x, y;
    coord_t     px, py;
    edge_t      w0, w1, w2;
    logic       covered;
    logic       advance;

    function automatic pix_coord_t int_part(coord_t c);
        return pix_coord_t'(c >>> SUBPIXEL_BITS);
    endfunction

    function automatic pix_coord_t min3(pix_coord_t a, pix_coord_t b, pix_coord_t c);
        pix_coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic pix_coord_t max3(pix_coord_t a, pix_coord_t b, pix_coord_t c);
        pix_coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // (p - a) x (b - a), non-negative on the inside for this winding
    function automatic edge_t edge_fn(vertex_t a, vertex_t b, coord_t sx, coord_t sy);
        edge_t dpx, dpy, dex, dey;
        dpx = edge_t'(sx) - edge_t'(a.x);
        dpy = edge_t'(sy) - edge_t'(a.y);
        dex = edge_t'(b.x) - edge_t'(a.x);
        dey = edge_t'(b.y) - edge_t'(a.y);
        return dpx * dey - dpy * dex;
    endfunction

    // clip box to the screen
    assign lo_x = (min_x < 0) ? '0 : min_x;
    assign lo_y = (min_y < 0) ? '0 : min_y;
    assign hi_x = (max_x > pix_coord_t'(FB_WIDTH - 1)) ? pix_coord_t'(FB_WIDTH - 1) : max_x;
    assign hi_y = (max_y > pix_coord_t'(FB_HEIGHT - 1)) ? pix_coord_t'(FB_HEIGHT - 1) : max_y;

    // sample at the integer pixel position
    assign px = coord_t'(x) <<< SUBPIXEL_BITS;
    assign py = coord_t'(y) <<< SUBPIXEL_BITS;

    assign w0 = edge_fn(tri_q.v1, tri_q.v2, px, py);
    assign w1 = edge_fn(tri_q.v2, tri_q.v0, px, py);
    assign w2 = edge_fn(tri_q.v0, tri_q.v1, px, py);
    assign covered = (w0 >= 0) && (w1 >= 0) && (w2 >= 0);

    assign wr_valid_o = (state == R_WALK) && covered;
    assign wr_o = '{addr: base_q + vram_addr_t'(y) * FB_WIDTH + vram_addr_t'(x),
                    data: tri_q.color};
    // an uncovered pixel never waits on the writer
    assign advance = (state == R_WALK) && (!covered || wr_ready_i);
    assign busy_o  = (state != R_IDLE);

    always_ff @(posedge clk) begin
        case (state)
            R_IDLE: begin
                if (start_i) begin
                    tri_q  <= tri_i;
                    base_q <= base_i;
                    min_x  <= min3(int_part(tri_i.v0.x), int_part(tri_i.v1.x), int_part(tri_i.v2.x));
                    min_y  <= min3(int_part(tri_i.v0.y), int_part(tri_i.v1.y), int_part(tri_i.v2.y));
                    max_x  <= max3(int_part(tri_i.v0.x), int_part(tri_i.v1.x), int_part(tri_i.v2.x));
                    max_y  <= max3(int_part(tri_i.v0.y), int_part(tri_i.v1.y), int_part(tri_i.v2.y));
                    state  <= R_SETUP;
                end
            end

            R_SETUP: begin
                min_x <= lo_x;
                max_x <= hi_x;
                max_y <= hi_y;
                x     <= lo_x;
                y     <= lo_y;
                // fully off-screen boxes skip the walk
                state <= (lo_x > hi_x || lo_y > hi_y) ? R_DRAIN : R_WALK;
            end

            R_WALK: begin
                if (advance) begin
                    if (x < max_x) begin
                        x <= x + pix_coord_t'(1);
                    end else begin
                        x <= min_x;
                        y <= y + pix_coord_t'(1);
                        if (y >= max_y) begin
                            state <= R_DRAIN;
                        end
                    end
                end
            end

            // last write has to reach VRAM before busy drops
            R_DRAIN: begin
                if (writer_idle_i) begin
                    state <= R_IDLE;
                end
            end

            default: state <= R_IDLE;
        endcase

        if (reset_i) begin
            state <= R_IDLE;
        end
    end

endmodule

/* hdl/fb_clear.sv */
// ############################
// Back buffer clear engine, one fill write per pixel
// ############################

`timescale 1ns/10ps

module fb_clear (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       start_i,
    input  raster_cfg_pkg::color_t     color_i,
    input  raster_cfg_pkg::vram_addr_t base_i,
    output logic                       wr_valid_o,
    output raster_cmd_pkg::pix_write_t wr_o,
    input  logic                       wr_ready_i,
    input  logic                       writer_idle_i,
    output logic                       busy_o
);
    import raster_cfg_pkg::*;

    typedef enum logic [1:0] {C_IDLE, C_FILL, C_DRAIN} state_e;

    state_e     state;
    vram_addr_t base_q;
    vram_addr_t offset;
    color_t     color_q;

    assign wr_valid_o = (state == C_FILL);
    assign wr_o       = '{addr: base_q + offset, data: color_q};
    assign busy_o     = (state != C_IDLE);

    always_ff @(posedge clk) begin
        case (state)
            C_IDLE: begin
                if (start_i) begin
                    base_q  <= base_i;
                    color_q <= color_i;
                    offset  <= '0;
                    state   <= C_FILL;
                end
            end

            C_FILL: begin
                if (wr_ready_i) begin
                    if (offset == vram_addr_t'(FB_PIXELS - 1)) begin
                        state <= C_DRAIN;
                    end else begin
                        offset <= offset + 1'b1;
                    end
                end
            end

            // wait for the final word to be acked
            C_DRAIN: begin
                if (writer_idle_i) begin
                    state <= C_IDLE;
                end
            end

            default: state <= C_IDLE;
        endcase

        if (reset_i) begin
            state <= C_IDLE;
        end
    end

endmodule

/* hdl/vram_writer.sv */
// ############################
// Single-entry write buffer in front of the VRAM
// sel/ack port, shared by both engines
// ############################

`timescale 1ns/10ps

module vram_writer (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       a_valid_i,
    input  raster_cmd_pkg::pix_write_t a_i,
    input  logic                       b_valid_i,
    input  raster_cmd_pkg::pix_write_t b_i,
    output logic                       ready_o,
    output logic                       idle_o,
    output logic                       vram_sel_o,
    output raster_cmd_pkg::pix_write_t vram_req_o,
    input  logic                       vram_ack_i
);
    import raster_cmd_pkg::*;

    pix_write_t buf_q;
    logic       full;

    assign ready_o    = !full;
    assign idle_o     = !full;
    // request is held from the buffer until ack
    assign vram_sel_o = full;
    assign vram_req_o = buf_q;

    always_ff @(posedge clk) begin
        if (!full) begin
            if (a_valid_i) begin
                buf_q <= a_i;
                full  <= 1'b1;
            end else if (b_valid_i) begin
                buf_q <= b_i;
                full  <= 1'b1;
            end
        end else if (vram_ack_i) begin
            full <= 1'b0;
        end

        if (reset_i) begin
            full <= 1'b0;
        end
    end

endmodule

/* hdl/raster_top.sv */
// ############################
// Rasterizer core top: command stream in,
// pixel writes out on the VRAM port
// ############################

`timescale 1ns/10ps

module raster_top (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       cmd_valid_i,
    output logic                       cmd_ready_o,
    input  logic [31:0]                cmd_data_i,
    output logic                       vram_sel_o,
    output raster_cmd_pkg::pix_write_t vram_req_o,
    input  logic                       vram_ack_i,
    input  logic                       vsync_i,
    output logic                       swap_o,
    output raster_cfg_pkg::vram_addr_t front_addr_o
);
    import raster_cfg_pkg::*;
    import raster_cmd_pkg::*;

    logic       raster_start, clear_start;
    logic       raster_busy, clear_busy;
    triangle_t  tri_data;
    color_t     clear_color;
    vram_addr_t back_base;

    logic       raster_wr_valid, clear_wr_valid;
    pix_write_t raster_wr, clear_wr;
    logic       wr_ready, writer_idle;

    cmd_decoder cmd_decoder_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_data_i    (cmd_data_i),
        .cmd_ready_o   (cmd_ready_o),
        .vsync_i       (vsync_i),
        .raster_busy_i (raster_busy),
        .clear_busy_i  (clear_busy),
        .raster_start_o(raster_start),
        .clear_start_o (clear_start),
        .tri_o         (tri_data),
        .clear_color_o (clear_color),
        .back_base_o   (back_base),
        .front_addr_o  (front_addr_o),
        .swap_o        (swap_o)
    );

    edge_rasterizer edge_rasterizer_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .start_i      (raster_start),
        .tri_i        (tri_data),
        .base_i       (back_base),
        .wr_valid_o   (raster_wr_valid),
        .wr_o         (raster_wr),
        .wr_ready_i   (wr_ready),
        .writer_idle_i(writer_idle),
        .busy_o       (raster_busy)
    );

    fb_clear fb_clear_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .start_i      (clear_start),
        .color_i      (clear_color),
        .base_i       (back_base),
        .wr_valid_o   (clear_wr_valid),
        .wr_o         (clear_wr),
        .wr_ready_i   (wr_ready),
        .writer_idle_i(writer_idle),
        .busy_o       (clear_busy)
    );

    vram_writer vram_writer_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .a_valid_i (raster_wr_valid),
        .a_i       (raster_wr),
        .b_valid_i (clear_wr_valid),
        .b_i       (clear_wr),
        .ready_o   (wr_ready),
        .idle_o    (writer_idle),
        .vram_sel_o(vram_sel_o),
        .vram_req_o(vram_req_o),
        .vram_ack_i(vram_ack_i)
    );

endmodule

/* dv/raster_top_assert.sv */
// ##############################
// Handshake and buffer swap checks that are
// bound into raster_top by the bind below
// ##############################

`timescale 1ns/10ps

module raster_top_assert (
    input logic                       clk,
    input logic                       reset_i,
    input logic                       vram_sel_i,
    input raster_cmd_pkg::pix_write_t vram_req_i,
    input logic                       vram_ack_i,
    input logic                       swap_i,
    input logic                       cmd_ready_i,
    input logic                       raster_busy_i,
    input logic                       clear_busy_i
);

    // number of failed assertions so far
    int fail_count = 0;

    // request held until the memory acks it
    req_stable: assert property (@(posedge clk) disable iff (reset_i)
        (vram_sel_i && !vram_ack_i) |=> (vram_sel_i && $stable(vram_req_i)))
        else begin
            fail_count++;
            $error("vram request changed or dropped before ack");
        end

    swap_single: assert property (@(posedge clk) disable iff (reset_i)
        swap_i |=> !swap_i)
        else begin
            fail_count++;
            $error("swap pulse longer than one cycle");
        end

    ready_vs_busy: assert property (@(posedge clk) disable iff (reset_i)
        (raster_busy_i || clear_busy_i) |-> !cmd_ready_i)
        else begin
            fail_count++;
            $error("command ready while an engine is busy");
        end

endmodule

bind raster_top raster_top_assert raster_top_assert_i (
    .clk          (clk),
    .reset_i      (reset_i),
    .vram_sel_i   (vram_sel_o),
    .vram_req_i   (vram_req_o),
    .vram_ack_i   (vram_ack_i),
    .swap_i       (swap_o),
    .cmd_ready_i  (cmd_ready_o),
    .raster_busy_i(raster_busy),
    .clear_busy_i (clear_busy)
);

/* dv/tb_raster_top.sv */
// ##############################
// Testbench for raster_top that runs a table of command
// sequences against a VRAM model with random ack delay
// and compares memory with a shadow framebuffer
// ##############################

`timescale 1ns/10ps

module tb_raster_top;
    import raster_cfg_pkg::*;
    import raster_cmd_pkg::*;

    typedef enum logic [2:0] {K_CLEAR, K_DRAW, K_RELOAD, K_SWAP, K_VSWAP} kind_e;

    typedef struct packed {
        kind_e      kind;
        coord_t     x0, y0, x1, y1, x2, y2;
        color_t     color;
        vram_addr_t exp_front;
        logic       exp_blank;
    } test_t;

    localparam int NUM_TESTS     = 10;
    localparam int MAX_ACK_DELAY = 3;
    localparam int VSYNC_HOLD    = 8;
    localparam int VRAM_WORDS    = 2 * FB_PIXELS;
    // every pixel can cost the ack delay plus refill cycles
    localparam int TIMEOUT_CYCLES = NUM_TESTS * FB_PIXELS * (MAX_ACK_DELAY + 3) + 500;

    logic        clk;
    logic        reset_i;
    logic        cmd_valid_i;
    logic        cmd_ready_o;
    logic [31:0] cmd_data_i;
    logic        vram_sel_o;
    pix_write_t  vram_req_o;
    logic        vram_ack_i = 1'b0;
    logic        vsync_i;
    logic        swap_o;
    vram_addr_t  front_addr_o;

    color_t vram   [VRAM_WORDS];
    color_t shadow [VRAM_WORDS];
    test_t  tests  [NUM_TESTS];

    integer seed = 75;
    int     ack_wait = -1;
    int     errors = 0;
    int     passed = 0;
    int     failed = 0;
    int     write_cnt = 0;
    int     swap_cnt = 0;
    int     cycles = 0;
    int     tb_front = FRONT_INIT_BASE;
    int     tb_back  = BACK_INIT_BASE;

    raster_top raster_top_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .cmd_data_i  (cmd_data_i),
        .vram_sel_o  (vram_sel_o),
        .vram_req_o  (vram_req_o),
        .vram_ack_i  (vram_ack_i),
        .vsync_i     (vsync_i),
        .swap_o      (swap_o),
        .front_addr_o(front_addr_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic color_t fill_word(int addr);
        return color_t'(addr) ^ 16'hb400;
    endfunction

    // memory model acks each request after 0 to MAX_ACK_DELAY cycles
    always @(negedge clk) begin
        if (reset_i) begin
            vram_ack_i <= 1'b0;
            ack_wait = -1;
            for (int a = 0; a < VRAM_WORDS; a++) begin
                vram[a] = fill_word(a);
            end
        end else if (vram_ack_i) begin
            vram_ack_i <= 1'b0;
            ack_wait = -1;
        end else if (vram_sel_o) begin
            if (ack_wait < 0) begin
                ack_wait = $unsigned($random(seed)) % (MAX_ACK_DELAY + 1);
            end
            if (ack_wait == 0) begin
                if (vram_req_o.addr < VRAM_WORDS) begin
                    vram[vram_req_o.addr] = vram_req_o.data;
                    write_cnt++;
                end else begin
                    $display("VRAM write outside both buffers, address %0h", vram_req_o.addr);
                    errors++;
                end
                vram_ack_i <= 1'b1;
            end else begin
                ack_wait = ack_wait - 1;
            end
        end
    end

    always @(negedge clk) begin
        if (swap_o) begin
            swap_cnt++;
        end
    end

    task automatic check_value(input string what, input longint got, input longint exp);
        if (got != exp) begin
            $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic test_t make_test(kind_e kind, int x0, int y0, int x1, int y1,
                                        int x2, int y2, int color, int front, bit blank);
        test_t t;
        t.kind      = kind;
        t.x0        = coord_t'(x0);
        t.y0        = coord_t'(y0);
        t.x1        = coord_t'(x1);
        t.y1        = coord_t'(y1);
        t.x2        = coord_t'(x2);
        t.y2        = coord_t'(y2);
        t.color     = color_t'(color);
        t.exp_front = vram_addr_t'(front);
        t.exp_blank = blank;
        return t;
    endfunction

    function automatic string kind_name(kind_e k);
        case (k)
            K_CLEAR:  return "clear";
            K_DRAW:   return "draw";
            K_RELOAD: return "reload and draw";
            K_SWAP:   return "swap";
            default:  return "swap on vsync";
        endcase
    endfunction

    function automatic longint edge_val(longint ax, longint ay, longint bx, longint by,
                                        longint px, longint py);
        return (px - ax) * (by - ay) - (py - ay) * (bx - ax);
    endfunction

    // coordinates in sixteenths of a pixel
    task automatic build_table();
        tests[0] = make_test(K_CLEAR, 0, 0, 0, 0, 0, 0, 16'h1c3a, FRONT_INIT_BASE, 1'b0);
        tests[1] = make_test(K_DRAW, 32, 16, 48, 192, 320, 64, 16'hf00d,
                             FRONT_INIT_BASE, 1'b0);
        // reaches past the top left and bottom right corners
        tests[2] = make_test(K_DRAW, -96, -64, 160, 480, 640, 32, 16'h07e0,
                             FRONT_INIT_BASE, 1'b0);
        tests[3] = make_test(K_DRAW, 72, 36, 108, 216, 437, 143, 16'h5a5a,
                             FRONT_INIT_BASE, 1'b0);
        tests[4] = make_test(K_DRAW, 32, 16, 320, 64, 48, 192, 16'hdead,
                             FRONT_INIT_BASE, 1'b1);
        tests[5] = make_test(K_SWAP, 0, 0, 0, 0, 0, 0, 0, BACK_INIT_BASE, 1'b0);
        tests[6] = make_test(K_CLEAR, 0, 0, 0, 0, 0, 0, 16'h3333, BACK_INIT_BASE, 1'b0);
        tests[7] = make_test(K_DRAW, 32, 16, 48, 192, 320, 64, 16'hc0de,
                             BACK_INIT_BASE, 1'b0);
        tests[8] = make_test(K_VSWAP, 0, 0, 0, 0, 0, 0, 0, FRONT_INIT_BASE, 1'b0);
        tests[9] = make_test(K_RELOAD, 16, 16, 40, 240, 500, 100, 16'h8421,
                             FRONT_INIT_BASE, 1'b0);
    endtask

    // called on a falling edge and returns on the falling edge after the transfer
    task automatic send_cmd(input opcode_e op, input logic [15:0] operand);
        cmd_data_i  = {op, 8'h00, operand};
        cmd_valid_i = 1'b1;
        check_value("cmd_ready_o when presenting a word", longint'(cmd_ready_o), 1);
        while (!cmd_ready_o) begin
            @(negedge clk);
        end
        @(negedge clk);
        cmd_valid_i = 1'b0;
    endtask

    task automatic load_triangle(input test_t t, input bit twice);
        opcode_e     ops [7];
        logic [15:0] vals [7];
        ops  = '{OP_SET_X0, OP_SET_Y0, OP_SET_X1, OP_SET_Y1, OP_SET_X2, OP_SET_Y2, OP_SET_COLOR};
        vals = '{t.x0, t.y0, t.x1, t.y1, t.x2, t.y2, t.color};
        // stale values go first so the draw has to pick up the second set
        if (twice) begin
            for (int k = 0; k < 7; k++) begin
                send_cmd(ops[k], vals[k] ^ 16'h0a50);
            end
        end
        for (int k = 0; k < 7; k++) begin
            send_cmd(ops[k], vals[k]);
        end
    endtask

    task automatic wait_idle();
        while (!cmd_ready_o) begin
            @(negedge clk);
        end
    endtask

    task automatic vsync_swap();
        send_cmd(OP_SWAP, 16'h0001);
        repeat (VSYNC_HOLD) begin
            check_value("cmd_ready_o while waiting for vsync", longint'(cmd_ready_o), 0);
            check_value("front_addr_o before vsync", front_addr_o, tb_front);
            @(negedge clk);
        end
        vsync_i = 1'b1;
        @(negedge clk);
        vsync_i = 1'b0;
    endtask

    task automatic model_clear(input color_t c);
        for (int i = 0; i < FB_PIXELS; i++) begin
            shadow[tb_back + i] = c;
        end
    endtask

    task automatic model_draw(input test_t t, output int n);
        longint px, py;
        n = 0;
        for (int y = 0; y < FB_HEIGHT; y++) begin
            for (int x = 0; x < FB_WIDTH; x++) begin
                px = longint'(x) * (1 << SUBPIXEL_BITS);
                py = longint'(y) * (1 << SUBPIXEL_BITS);
                if (edge_val(t.x1, t.y1, t.x2, t.y2, px, py) >= 0 &&
                    edge_val(t.x2, t.y2, t.x0, t.y0, px, py) >= 0 &&
                    edge_val(t.x0, t.y0, t.x1, t.y1, px, py) >= 0) begin
                    shadow[tb_back + y * FB_WIDTH + x] = t.color;
                    n++;
                end
            end
        end
    endtask

    task automatic model_swap();
        int tmp;
        tmp      = tb_front;
        tb_front = tb_back;
        tb_back  = tmp;
    endtask

    initial begin
        test_t t;
        int    errs_before, writes_before, swaps_before, exp_writes, exp_swaps;
        reset_i     = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_data_i  = '0;
        vsync_i     = 1'b0;
        build_table();
        for (int a = 0; a < VRAM_WORDS; a++) begin
            shadow[a] = fill_word(a);
        end
        repeat (5) @(negedge clk);
        reset_i = 1'b0;
        check_value("front_addr_o after reset", front_addr_o, FRONT_INIT_BASE);
        check_value("cmd_ready_o after reset", longint'(cmd_ready_o), 1);
        check_value("vram_sel_o after reset", longint'(vram_sel_o), 0);
        check_value("swap_o after reset", longint'(swap_o), 0);

        for (int i = 0; i < NUM_TESTS; i++) begin
            t             = tests[i];
            errs_before   = errors;
            writes_before = write_cnt;
            swaps_before  = swap_cnt;
            exp_writes    = 0;
            exp_swaps     = 0;
            case (t.kind)
                K_CLEAR: begin
                    send_cmd(OP_CLEAR, t.color);
                    model_clear(t.color);
                    exp_writes = FB_PIXELS;
                end
                K_DRAW, K_RELOAD: begin
                    load_triangle(t, t.kind == K_RELOAD);
                    send_cmd(OP_DRAW, 16'h0000);
                    model_draw(t, exp_writes);
                end
                K_SWAP: begin
                    send_cmd(OP_SWAP, 16'h0000);
                    model_swap();
                    exp_swaps = 1;
                end
                default: begin
                    vsync_swap();
                    model_swap();
                    exp_swaps = 1;
                end
            endcase
            wait_idle();

            check_value("front_addr_o", front_addr_o, t.exp_front);
            check_value("swap_o pulse count", swap_cnt - swaps_before, exp_swaps);
            check_value("pixel writes", write_cnt - writes_before, exp_writes);
            if (t.exp_blank) begin
                check_value("writes for reversed winding", write_cnt - writes_before, 0);
            end
            for (int a = 0; a < VRAM_WORDS; a++) begin
                check_value($sformatf("vram word %0d", a), vram[a], shadow[a]);
            end

            if (errors == errs_before) begin
                passed++;
                $display("test %0d (%s): ok", i, kind_name(t.kind));
            end else begin
                failed++;
                $display("test %0d (%s): %0d mismatches", i, kind_name(t.kind),
                         errors - errs_before);
            end
        end

        errors += raster_top_i.raster_top_assert_i.fail_count;
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, passed, failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/raster_cfg_pkg.sv
hdl/raster_cmd_pkg.sv
hdl/cmd_decoder.sv
hdl/edge_rasterizer.sv
hdl/fb_clear.sv
hdl/vram_writer.sv
hdl/raster_top.sv
dv/raster_top_assert.sv
dv/tb_raster_top.sv

/* Makefile */
# Verilator build and run for the rasterizer core testbench
# every variable can be overridden on the command line

VERILATOR  ?= verilator
TOP        ?= tb_raster_top
RTL_TOP    ?= raster_top
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= hdl/raster_cfg_pkg.sv hdl/raster_cmd_pkg.sv hdl/cmd_decoder.sv \
              hdl/edge_rasterizer.sv hdl/fb_clear.sv hdl/vram_writer.sv hdl/raster_top.sv
PASS_MSG   ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
